/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= decoderTb
FILELIST  ?= sim.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q -F '** FAIL **' $(LOG); then exit 1; fi
	@grep -q -F '** PASS **' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* branchCondition.sv */
`timescale 1ns/1ns

module branchCondition (
    input  decoderPkg::condT cond,
    input  decoderPkg::psrT  psr,
    output logic             conditionTrue
);

    logic negFlag;
    logic zeroFlag;
    logic fFlag;
    logic lowFlag;
    logic carryFlag;

    assign negFlag   = psr[decoderPkg::NegBit];
    assign zeroFlag  = psr[decoderPkg::ZeroBit];
    assign fFlag     = psr[decoderPkg::FlagBit];
    assign lowFlag   = psr[decoderPkg::LowBit];
    assign carryFlag = psr[decoderPkg::CarryBit];

    // One table serves both Jcond and Bcond
    always_comb begin
        conditionTrue = 1'b0;
        case (cond)
            decoderPkg::Eq:            conditionTrue = zeroFlag;
            decoderPkg::Neq:           conditionTrue = !zeroFlag;
            decoderPkg::GreaterThan:   conditionTrue = negFlag;
            decoderPkg::Geq:           conditionTrue = negFlag || zeroFlag;
            decoderPkg::LessThan:      conditionTrue = !negFlag && !zeroFlag;
            decoderPkg::Leq:           conditionTrue = !negFlag;
            decoderPkg::CarrySet:      conditionTrue = carryFlag;
            decoderPkg::CarryClear:    conditionTrue = !carryFlag;
            decoderPkg::HigherThan:    conditionTrue = lowFlag; // Unsigned compare uses L
            decoderPkg::LowerOrSame:   conditionTrue = !lowFlag;
            decoderPkg::HigherOrSame:  conditionTrue = lowFlag || zeroFlag;
            decoderPkg::Lo:            conditionTrue = !lowFlag && !zeroFlag;
            decoderPkg::Fset:          conditionTrue = fFlag;
            decoderPkg::Fclear:        conditionTrue = !fFlag;
            decoderPkg::Unconditional: conditionTrue = 1'b1;
            decoderPkg::NoJump:        conditionTrue = 1'b0;
            default:                   conditionTrue = 1'b0;
        endcase
    end

endmodule

/* controlDecode.sv */
`timescale 1ns/1ns

module controlDecode (
    input  logic                 clk,
    input  logic                 rstN,
    input  decoderPkg::instrT    instruction,
    input  logic                 conditionTrue,
    output logic                 pcWrite,
    output logic                 ramWriteEnable,
    output logic                 regWriteEnable,
    output logic                 useImmediate,
    output logic                 regOperandSel,
    output logic                 writeBackFromAlu,
    output decoderPkg::immSelT   immSel,
    output decoderPkg::regAddrT  regWriteAddr,
    output decoderPkg::instrT    instructionOut
);

    decoderPkg::opcodeT  opcode;
    logic [3:0]          ext;

    logic                pcWriteNext;
    logic                ramWriteNext;
    logic                regWriteNext;
    logic                useImmNext;
    logic                regOperandNext;
    logic                writeBackAluNext;
    decoderPkg::immSelT  immSelNext;
    decoderPkg::regAddrT regWriteAddrNext;
    decoderPkg::instrT   instrNext;

    assign opcode = decoderPkg::opcodeT'(instruction[15:12]);
    assign ext    = instruction[7:4];

    always_comb begin
        pcWriteNext      = 1'b0;
        ramWriteNext     = 1'b0;
        regWriteNext     = 1'b0;
        useImmNext       = 1'b0;
        regOperandNext   = 1'b1;               // Register operand, not PC
        writeBackAluNext = 1'b1;
        immSelNext       = decoderPkg::ImmRaw;
        regWriteAddrNext = instruction[11:8];
        instrNext        = instruction;        // Most words reach the ALU as they are

        case (opcode)
            decoderPkg::Rtype: begin
                regWriteNext = (ext != decoderPkg::ExtCompare); // Compare only sets the PSR
            end
            decoderPkg::Shift: begin
                regWriteNext = 1'b1;
                if (ext != decoderPkg::ExtLsh) begin
                    useImmNext = 1'b1;                           // LSHI
                    immSelNext = decoderPkg::ImmRaw;
                end
            end
            decoderPkg::Lui: begin
                useImmNext   = 1'b1;
                immSelNext   = decoderPkg::ImmRaw;
                regWriteNext = 1'b1;
            end
            decoderPkg::Addi, decoderPkg::Addui, decoderPkg::Subi: begin
                useImmNext   = 1'b1;
                immSelNext   = decoderPkg::ImmSignExt;
                regWriteNext = 1'b1;
            end
            decoderPkg::Cmpi: begin
                useImmNext = 1'b1;
                immSelNext = decoderPkg::ImmSignExt;
            end
            decoderPkg::Andi, decoderPkg::Ori, decoderPkg::Xori, decoderPkg::Movi: begin
                useImmNext   = 1'b1;
                immSelNext   = decoderPkg::ImmZeroExt;
                regWriteNext = 1'b1;
            end
            decoderPkg::MemJump: begin
                case (ext)
                    decoderPkg::ExtLoad: begin
                        useImmNext       = 1'b1;
                        immSelNext       = decoderPkg::ImmZero; // Address is the register alone
                        regWriteNext     = 1'b1;
                        writeBackAluNext = 1'b0;                // Data comes back from RAM
                        instrNext = {4'b0000, instruction[11:8], decoderPkg::ExtAddu,
                                     instruction[3:0]};
                    end
                    decoderPkg::ExtStore: begin
                        ramWriteNext = 1'b1;
                        instrNext = {4'b0000, instruction[3:0], decoderPkg::ExtAddu,
                                     instruction[11:8]};        // Fields swap for the address
                    end
                    decoderPkg::ExtJcond: begin
                        if (conditionTrue) begin
                            useImmNext  = 1'b1;
                            immSelNext  = decoderPkg::ImmZero;
                            pcWriteNext = 1'b1;
                            instrNext = {4'b0000, decoderPkg::RegZero, decoderPkg::ExtAddu,
                                         instruction[3:0]};     // Target taken from the register
                        end else begin
                            instrNext = decoderPkg::NopInstr;
                        end
                    end
                    default: begin
                        // JAL and unused sub-codes pass through with enables off
                    end
                endcase
            end
            decoderPkg::Bcond: begin
                if (conditionTrue) begin
                    regOperandNext = 1'b0;                      // PC feeds the ALU
                    useImmNext     = 1'b1;
                    immSelNext     = decoderPkg::ImmSignExt;
                    pcWriteNext    = 1'b1;
                    instrNext = {decoderPkg::Addi, decoderPkg::RegZero, instruction[7:0]};
                end else begin
                    instrNext = decoderPkg::NopInstr;
                end
            end
            default: begin
                // Unknown opcodes leave every default in place
            end
        endcase
    end

    // Decode to execute boundary
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcWrite          <= 1'b0;
            ramWriteEnable   <= 1'b0;
            regWriteEnable   <= 1'b0;
            useImmediate     <= 1'b0;
            regOperandSel    <= 1'b1;
            writeBackFromAlu <= 1'b1;
            immSel           <= decoderPkg::ImmRaw;
            regWriteAddr     <= '0;
            instructionOut   <= decoderPkg::NopInstr;
        end else begin
            pcWrite          <= pcWriteNext;
            ramWriteEnable   <= ramWriteNext;
            regWriteEnable   <= regWriteNext;
            useImmediate     <= useImmNext;
            regOperandSel    <= regOperandNext;
            writeBackFromAlu <= writeBackAluNext;
            immSel           <= immSelNext;
            regWriteAddr     <= regWriteAddrNext;
            instructionOut   <= instrNext;
        end
    end

endmodule

/* decoderPkg.sv */
package decoderPkg;

    typedef logic [15:0] instrT;  // One instruction word
    typedef logic [3:0]  regAddrT; // Register file address
    typedef logic [4:0]  psrT;    // N Z F L C, MSB first

    // Flag positions inside psrT
    localparam int NegBit   = 4;
    localparam int ZeroBit  = 3;
    localparam int FlagBit  = 2;
    localparam int LowBit   = 1;
    localparam int CarryBit = 0;

    // Major opcodes in bits 15 to 12
    typedef enum logic [3:0] {
        Rtype    = 4'b0000,
        Andi     = 4'b0001,
        Ori      = 4'b0010,
        Xori     = 4'b0011,
        MemJump  = 4'b0100, // Load, store and jumps share this one
        Addi     = 4'b0101,
        Addui    = 4'b0110,
        Shift    = 4'b1000,
        Subi     = 4'b1001,
        Cmpi     = 4'b1011,
        Bcond    = 4'b1100,
        Movi     = 4'b1101,
        Lui      = 4'b1111
    } opcodeT;

    // Condition codes in bits 11 to 8 of Jcond and Bcond
    typedef enum logic [3:0] {
        Eq            = 4'b0000,
        Neq           = 4'b0001,
        CarrySet      = 4'b0010,
        CarryClear    = 4'b0011,
        HigherThan    = 4'b0100,
        LowerOrSame   = 4'b0101,
        GreaterThan   = 4'b0110,
        Leq           = 4'b0111,
        Fset          = 4'b1000,
        Fclear        = 4'b1001,
        Lo            = 4'b1010,
        HigherOrSame  = 4'b1011,
        LessThan      = 4'b1100,
        Geq           = 4'b1101,
        Unconditional = 4'b1110,
        NoJump        = 4'b1111
    } condT;

    // How the datapath forms the immediate operand
    typedef enum logic [1:0] {
        ImmRaw     = 2'd0,
        ImmSignExt = 2'd1,
        ImmZeroExt = 2'd2,
        ImmZero    = 2'd3  // Operand forced to zero
    } immSelT;

    // Extension codes in bits 7 to 4
    localparam logic [3:0] ExtCompare = 4'b1011;
    localparam logic [3:0] ExtLsh     = 4'b0100;
    localparam logic [3:0] ExtLoad    = 4'b0000;
    localparam logic [3:0] ExtStore   = 4'b0100;
    localparam logic [3:0] ExtJcond   = 4'b1100;
    localparam logic [3:0] ExtAddu    = 4'b0110;

    localparam regAddrT RegZero  = 4'b0000;
    localparam instrT   NopInstr = 16'h0020; // OR r0,r0

endpackage

/* decoderProps.sv */
`timescale 1ns/1ns

module decoderProps (
    input logic clk,
    input logic rstN,
    input logic pcWrite,
    input logic ramWriteEnable,
    input logic regWriteEnable
);

    // A store never writes back to the register file
    noDoubleWrite: assert property (@(posedge clk) disable iff (!rstN)
        !(ramWriteEnable && regWriteEnable))
        else $error("RAM and register writes both enabled");

    pcWriteNoReg: assert property (@(posedge clk) disable iff (!rstN)
        pcWrite |-> !regWriteEnable)
        else $error("PC write together with register write");

    enablesOffInReset: assert property (@(posedge clk)
        !rstN |-> !(pcWrite || ramWriteEnable || regWriteEnable))
        else $error("Write enable active during reset");

endmodule

bind controlDecode decoderProps u_decoderProps (
    .clk            (clk),
    .rstN           (rstN),
    .pcWrite        (pcWrite),
    .ramWriteEnable (ramWriteEnable),
    .regWriteEnable (regWriteEnable)
);

/* decoderRef.svh */
`ifndef DECODER_REF_SVH
`define DECODER_REF_SVH

// Expected decode outputs for one instruction word
typedef struct packed {
    logic                pcWrite;
    logic                ramWrite;
    logic                regWrite;
    logic                useImm;
    logic                regOperand;
    logic                writeBackAlu;
    decoderPkg::immSelT  immSel;
    decoderPkg::regAddrT regAddr;
    decoderPkg::instrT   instr;
} expT;

// Condition table shared by Jcond and Bcond
function automatic logic condTaken(input logic [3:0] cond, input decoderPkg::psrT flags);
    logic n;
    logic z;
    logic f;
    logic l;
    logic c;
    n = flags[decoderPkg::NegBit];
    z = flags[decoderPkg::ZeroBit];
    f = flags[decoderPkg::FlagBit];
    l = flags[decoderPkg::LowBit];
    c = flags[decoderPkg::CarryBit];
    case (decoderPkg::condT'(cond))
        decoderPkg::Eq:            return z;
        decoderPkg::Neq:           return !z;
        decoderPkg::GreaterThan:   return n;
        decoderPkg::Geq:           return n || z;
        decoderPkg::LessThan:      return !n && !z;
        decoderPkg::Leq:           return !n;
        decoderPkg::CarrySet:      return c;
        decoderPkg::CarryClear:    return !c;
        decoderPkg::HigherThan:    return l;
        decoderPkg::LowerOrSame:   return !l;
        decoderPkg::HigherOrSame:  return l || z;
        decoderPkg::Lo:            return !l && !z;
        decoderPkg::Fset:          return f;
        decoderPkg::Fclear:        return !f;
        decoderPkg::Unconditional: return 1'b1;
        default:                   return 1'b0; // NoJump
    endcase
endfunction

function automatic expT decodeRef(input decoderPkg::instrT word, input decoderPkg::psrT flags);
    expT        e;
    logic [3:0] ext;
    logic       taken;
    ext            = word[7:4];
    taken          = condTaken(word[11:8], flags);
    e.pcWrite      = 1'b0;
    e.ramWrite     = 1'b0;
    e.regWrite     = 1'b0;
    e.useImm       = 1'b0;
    e.regOperand   = 1'b1;
    e.writeBackAlu = 1'b1;
    e.immSel       = decoderPkg::ImmRaw;
    e.regAddr      = word[11:8];
    e.instr        = word;
    case (decoderPkg::opcodeT'(word[15:12]))
        decoderPkg::Rtype: e.regWrite = (ext != decoderPkg::ExtCompare);
        decoderPkg::Shift: begin
            e.regWrite = 1'b1;
            e.useImm   = (ext != decoderPkg::ExtLsh); // LSHI takes the raw immediate
        end
        decoderPkg::Lui: begin
            e.useImm   = 1'b1;
            e.regWrite = 1'b1;
        end
        decoderPkg::Addi, decoderPkg::Addui, decoderPkg::Subi, decoderPkg::Cmpi: begin
            e.useImm   = 1'b1;
            e.immSel   = decoderPkg::ImmSignExt;
            e.regWrite = (word[15:12] != decoderPkg::Cmpi);
        end
        decoderPkg::Andi, decoderPkg::Ori, decoderPkg::Xori, decoderPkg::Movi: begin
            e.useImm   = 1'b1;
            e.immSel   = decoderPkg::ImmZeroExt;
            e.regWrite = 1'b1;
        end
        decoderPkg::MemJump: begin
            if (ext == decoderPkg::ExtLoad) begin
                e.useImm       = 1'b1;
                e.immSel       = decoderPkg::ImmZero;
                e.regWrite     = 1'b1;
                e.writeBackAlu = 1'b0;
                e.instr = {4'h0, word[11:8], decoderPkg::ExtAddu, word[3:0]};
            end else if (ext == decoderPkg::ExtStore) begin
                e.ramWrite = 1'b1;
                e.instr    = {4'h0, word[3:0], decoderPkg::ExtAddu, word[11:8]};
            end else if (ext == decoderPkg::ExtJcond) begin
                e.pcWrite = taken;
                e.useImm  = taken;
                e.immSel  = taken ? decoderPkg::ImmZero : decoderPkg::ImmRaw;
                e.instr   = taken ? {8'h00, decoderPkg::ExtAddu, word[3:0]} : decoderPkg::NopInstr;
            end
        end
        decoderPkg::Bcond: begin
            e.pcWrite    = taken;
            e.useImm     = taken;
            e.regOperand = !taken;                  // PC is the operand when taken
            e.immSel     = taken ? decoderPkg::ImmSignExt : decoderPkg::ImmRaw;
            e.instr      = taken ? {4'b0101, 4'h0, word[7:0]} : decoderPkg::NopInstr;
        end
        default: begin
        end
    endcase
    return e;
endfunction

task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        errorCount++;
        $display("[FAIL] %0t ns: %s %s got %b expected %b", $time, curCtx, name, got, exp);
    end
endtask

task automatic checkImmSel(input decoderPkg::immSelT got, input decoderPkg::immSelT exp);
    if (got !== exp) begin
        errorCount++;
        $display("[FAIL] %0t ns: %s immSel got %0d expected %0d", $time, curCtx, got, exp);
    end
endtask

task automatic checkRegAddr(input decoderPkg::regAddrT got, input decoderPkg::regAddrT exp);
    if (got !== exp) begin
        errorCount++;
        $display("[FAIL] %0t ns: %s regWriteAddr got %h expected %h", $time, curCtx, got, exp);
    end
endtask

task automatic checkInstr(input decoderPkg::instrT got, input decoderPkg::instrT exp);
    if (got !== exp) begin
        errorCount++;
        $display("[FAIL] %0t ns: %s instructionOut got %h expected %h", $time, curCtx, got, exp);
    end
endtask

`endif

/* decoderTb.sv */
`timescale 1ns/1ns

module decoderTb;

    localparam int          ClkPeriod   = 4;
    localparam int          ResetCycles = 8;
    localparam int          RandomCount = 2000;
    localparam int          DrainLimit  = 20;
    localparam logic [31:0] Seed        = 32'h54d9;

    logic                clk;
    logic                rstN;
    decoderPkg::instrT   instruction;
    decoderPkg::psrT     psr;
    logic                pcWrite;
    logic                ramWriteEnable;
    logic                regWriteEnable;
    logic                useImmediate;
    logic                regOperandSel;
    logic                writeBackFromAlu;
    decoderPkg::immSelT  immSel;
    decoderPkg::regAddrT regWriteAddr;
    decoderPkg::instrT   instructionOut;

    int          errorCount   = 0;
    int          pushedCount  = 0;
    int          checkedCount = 0;
    logic        timedOut     = 1'b0;
    string       curCtx;
    logic [31:0] rngState     = Seed;

    `include "decoderRef.svh"

    typedef struct packed {
        decoderPkg::instrT instr;
        decoderPkg::psrT   flags;
    } stimT;

    stimT pending[$]; // Words driven but not yet checked

    instructionDecoder DUT (
        .clk              (clk),
        .rstN             (rstN),
        .instruction      (instruction),
        .psr              (psr),
        .pcWrite          (pcWrite),
        .ramWriteEnable   (ramWriteEnable),
        .regWriteEnable   (regWriteEnable),
        .useImmediate     (useImmediate),
        .regOperandSel    (regOperandSel),
        .writeBackFromAlu (writeBackFromAlu),
        .immSel           (immSel),
        .regWriteAddr     (regWriteAddr),
        .instructionOut   (instructionOut)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    function automatic logic [31:0] nextRandom();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    task automatic applyWord(input decoderPkg::instrT word, input decoderPkg::psrT flags);
        @(posedge clk);
        #1;
        instruction = word;
        psr         = flags;
        pending.push_back({word, flags});
        pushedCount++;
    endtask

    task automatic waitDrained();
        int cycles;
        cycles = 0;
        while (checkedCount != pushedCount && cycles < DrainLimit) begin
            @(posedge clk);
            cycles++;
        end
        if (checkedCount != pushedCount) begin
            $display("Timeout: %0d decodes were never checked", pushedCount - checkedCount);
            timedOut = 1'b1;
        end
    endtask

    task automatic reportTest(input string name, input int errBefore, input int wordsBefore);
        waitDrained();
        $display("Test %-7s %5d words, %0d errors", name, pushedCount - wordsBefore,
                 errorCount - errBefore);
    endtask

    // Each decode is checked one cycle after the edge that sampled it
    initial begin : compareProc
        stimT s;
        expT  e;
        forever begin
            @(posedge clk);
            if (pending.size() > 0) begin
                s = pending.pop_front();
                e = decodeRef(s.instr, s.flags);
                @(negedge clk);
                curCtx = $sformatf("instr %h psr %b", s.instr, s.flags);
                checkBit("pcWrite", pcWrite, e.pcWrite);
                checkBit("ramWriteEnable", ramWriteEnable, e.ramWrite);
                checkBit("regWriteEnable", regWriteEnable, e.regWrite);
                checkBit("useImmediate", useImmediate, e.useImm);
                checkBit("regOperandSel", regOperandSel, e.regOperand);
                checkBit("writeBackFromAlu", writeBackFromAlu, e.writeBackAlu);
                checkImmSel(immSel, e.immSel);
                checkRegAddr(regWriteAddr, e.regAddr);
                checkInstr(instructionOut, e.instr);
                checkedCount++;
            end
        end
    end

    initial begin
        decoderPkg::opcodeT aluOps [11];
        int                 errBefore;
        int                 wordsBefore;
        logic [31:0]        r;
        logic [31:0]        q;
        rstN        = 1'b1;
        instruction = decoderPkg::NopInstr;
        psr         = '0;
        aluOps = '{decoderPkg::Rtype, decoderPkg::Shift, decoderPkg::Addi, decoderPkg::Addui,
                   decoderPkg::Subi, decoderPkg::Cmpi, decoderPkg::Andi, decoderPkg::Ori,
                   decoderPkg::Xori, decoderPkg::Movi, decoderPkg::Lui};
        #1 rstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        #1;
        errBefore = errorCount;
        curCtx    = "reset";
        checkBit("pcWrite", pcWrite, 1'b0);
        checkBit("ramWriteEnable", ramWriteEnable, 1'b0);
        checkBit("regWriteEnable", regWriteEnable, 1'b0);
        checkBit("useImmediate", useImmediate, 1'b0);
        checkBit("regOperandSel", regOperandSel, 1'b1);
        checkBit("writeBackFromAlu", writeBackFromAlu, 1'b1);
        checkImmSel(immSel, decoderPkg::ImmRaw);
        checkRegAddr(regWriteAddr, 4'h0);
        checkInstr(instructionOut, decoderPkg::NopInstr);
        reportTest("reset", errBefore, pushedCount);
        rstN = 1'b1;

        errBefore   = errorCount;
        wordsBefore = pushedCount;
        for (int round = 0; round < 4; round++) begin
            foreach (aluOps[k]) begin
                r = nextRandom();
                applyWord({aluOps[k], r[27:16]}, decoderPkg::psrT'(r[31:27]));
            end
            r = nextRandom();
            applyWord({4'h0, r[27:24], decoderPkg::ExtCompare, r[19:16]}, 5'h00);
            applyWord({4'h8, r[23:20], decoderPkg::ExtLsh, r[31:28]}, 5'h1f);
        end
        reportTest("alu", errBefore, wordsBefore);

        errBefore   = errorCount;
        wordsBefore = pushedCount;
        for (int i = 0; i < 8; i++) begin
            r = nextRandom();
            applyWord({4'h4, r[31:28], decoderPkg::ExtLoad, r[27:24]}, r[20:16]);
            applyWord({4'h4, r[27:24], decoderPkg::ExtStore, r[31:28]}, r[20:16]);
            applyWord({4'h4, r[23:20], 4'b1000, r[19:16]}, r[20:16]); // JAL passes through
        end
        reportTest("mem", errBefore, wordsBefore);

        errBefore   = errorCount;
        wordsBefore = pushedCount;
        for (int c = 0; c < 16; c++) begin
            for (int p = 0; p < 32; p++) begin
                r = nextRandom();
                applyWord({4'h4, c[3:0], decoderPkg::ExtJcond, r[31:28]}, p[4:0]);
                applyWord({4'hc, c[3:0], r[31:24]}, p[4:0]);
            end
        end
        reportTest("cond", errBefore, wordsBefore);

        errBefore   = errorCount;
        wordsBefore = pushedCount;
        for (int i = 0; i < RandomCount; i++) begin
            r = nextRandom();
            q = nextRandom();
            applyWord(r[31:16], q[31:27]);
        end
        reportTest("random", errBefore, wordsBefore);

        $display("Checked %0d decodes, %0d errors, timeout %0d", checkedCount, errorCount,
                 timedOut);
        if (errorCount == 0 && !timedOut) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* instructionDecoder.sv */
`timescale 1ns/1ns

module instructionDecoder (
    input  logic                 clk,
    input  logic                 rstN,
    input  decoderPkg::instrT    instruction,
    input  decoderPkg::psrT      psr,
    output logic                 pcWrite,
    output logic                 ramWriteEnable,
    output logic                 regWriteEnable,
    output logic                 useImmediate,
    output logic                 regOperandSel,
    output logic                 writeBackFromAlu,
    output decoderPkg::immSelT   immSel,
    output decoderPkg::regAddrT  regWriteAddr,
    output decoderPkg::instrT    instructionOut
);

    logic conditionTrue; // Same decision for jumps and branches

    branchCondition u_branchCondition (
        .cond          (decoderPkg::condT'(instruction[11:8])),
        .psr           (psr),
        .conditionTrue (conditionTrue)
    );

    controlDecode u_controlDecode (
        .clk              (clk),
        .rstN             (rstN),
        .instruction      (instruction),
        .conditionTrue    (conditionTrue),
        .pcWrite          (pcWrite),
        .ramWriteEnable   (ramWriteEnable),
        .regWriteEnable   (regWriteEnable),
        .useImmediate     (useImmediate),
        .regOperandSel    (regOperandSel),
        .writeBackFromAlu (writeBackFromAlu),
        .immSel           (immSel),
        .regWriteAddr     (regWriteAddr),
        .instructionOut   (instructionOut)
    );

endmodule

/* sim.f */
+incdir+.
decoderPkg.sv
branchCondition.sv
controlDecode.sv
instructionDecoder.sv
decoderProps.sv
decoderTb.sv
